/* source/video_regs_pkg.sv */
/* register map, bus widths and the BPLCON1 scroll layout of the bitplane path
   shared by the register block, the top level and the testbench */
package video_regs_pkg;

  // bus widths
  localparam int DATA_W = 16;                 // register bus word
  localparam int WIDE_W = 48;                 // extra bits from the wide chip-memory port

  // -------------------
  // register addresses, decoded on bits 8:1
  localparam logic [8:0] BPLCON0  = 9'h100;
  localparam logic [8:0] BPLCON1  = 9'h102;
  localparam logic [8:0] BPLCON2  = 9'h104;
  localparam logic [8:0] BPL1DAT  = 9'h110;   // writing this one starts a new fetch word
  localparam logic [8:0] BPL2DAT  = 9'h112;
  localparam logic [8:0] BPL3DAT  = 9'h114;
  localparam logic [8:0] BPL4DAT  = 9'h116;
  localparam logic [8:0] BPL5DAT  = 9'h118;
  localparam logic [8:0] BPL6DAT  = 9'h11a;
  localparam logic [8:0] BPL7DAT  = 9'h11c;
  localparam logic [8:0] BPL8DAT  = 9'h11e;
  localparam logic [8:0] FMODE    = 9'h1fc;
  localparam logic [8:0] REG_IDLE = 9'h1fe;   // no-op slot, bus parks here between writes

  localparam int BPLCON0_DBLPF  = 10;         // dual playfield enable
  localparam int BPLCON2_PF2PRI = 6;          // playfield 2 in front

  localparam logic [15:0] BPLCON1_RESET  = 16'h3300;
  localparam logic [7:0]  BPLCON1_OCS_HI = 8'h33;  // upper byte forced on non-aga writes

  // BPLCON1 seen as scroll fields
  typedef struct packed {
    logic [1:0] pf2_hi;     // bits 15:14, scroll 5:4 of playfield 2
    logic [1:0] pf2_sub;    // sub-pixel steps, hires only
    logic [1:0] pf1_hi;     // bits 11:10
    logic [1:0] pf1_sub;
    logic [3:0] pf2_fine;   // bits 7:4, the classic ocs scroll
    logic [3:0] pf1_fine;   // bits 3:0
  } bplcon1_fields_t;

  typedef union packed {
    logic [DATA_W-1:0] raw;   // as written on the bus
    bplcon1_fields_t   f;     // as used by the scroll latches
  } bplcon1_t;

endpackage

/* source/pixel_pkg.sv */
/* datapath constants for the shifters and the priority stage
   plane count, fetch widths, scroll range and colour index size */
package pixel_pkg;

  localparam int NUM_PLANES = 8;    // bitplanes per pixel
  localparam int FETCH_W    = 64;   // widest plane buffer
  localparam int SCROLL_W   = 6;    // scroll 0..63 pixels
  localparam int COLOR_W    = 8;    // colour index out of the priority stage

  // -------------------
  // fetch width codes from FMODE bits 1:0
  localparam logic [1:0] FMODE_16 = 2'd0;   // plain 16 bit words
  localparam logic [1:0] FMODE_32 = 2'd1;   // code 2 also means 32 bits
  localparam logic [1:0] FMODE_64 = 2'd3;   // full wide fetch

endpackage

/* source/bitplane_regs.sv */
/* bitplane register block, turns bus writes into control bits, plane buffers,
   the shifter load pulse and the latched playfield scroll values */
`timescale 1ns/1ps

module bitplane_regs (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              aga,          // aga registers writable
  input  logic [8:1]                        reg_addr,     // REG_IDLE when no write
  input  logic [video_regs_pkg::DATA_W-1:0] reg_data,
  input  logic [video_regs_pkg::WIDE_W-1:0] chip48,       // extra fetch bits
  output logic                              load,         // one cycle after BPL1DAT write
  output logic [1:0]                        fmode,
  output logic [pixel_pkg::FETCH_W-1:0]     plane1_data,
  output logic [pixel_pkg::FETCH_W-1:0]     plane2_data,
  output logic [pixel_pkg::FETCH_W-1:0]     plane3_data,
  output logic [pixel_pkg::FETCH_W-1:0]     plane4_data,
  output logic [pixel_pkg::FETCH_W-1:0]     plane5_data,
  output logic [pixel_pkg::FETCH_W-1:0]     plane6_data,
  output logic [pixel_pkg::FETCH_W-1:0]     plane7_data,
  output logic [pixel_pkg::FETCH_W-1:0]     plane8_data,
  output logic [pixel_pkg::SCROLL_W-1:0]    pf1_scroll,   // odd planes
  output logic [pixel_pkg::SCROLL_W-1:0]    pf2_scroll,   // even planes
  output logic                              dual_pf,
  output logic                              pf2_pri
);
  import video_regs_pkg::*;
  import pixel_pkg::*;

  bplcon1_t              bplcon1;                  // scroll register
  logic                  wr;                       // bus cycle carries a write
  logic                  sel_con0;
  logic                  sel_con1;
  logic                  sel_con2;
  logic                  sel_fmode;
  logic [NUM_PLANES-1:0] sel_dat;                  // bit 0 is BPL1DAT
  logic [WIDE_W-1:0]     wide;                     // lower buffer bits after masking
  logic [FETCH_W-1:0]    plane_buf [NUM_PLANES];

  // --------------------
  // address decode
  assign wr        = (reg_addr != REG_IDLE[8:1]);
  assign sel_con0  = wr && (reg_addr == BPLCON0[8:1]);
  assign sel_con1  = wr && (reg_addr == BPLCON1[8:1]);
  assign sel_con2  = wr && (reg_addr == BPLCON2[8:1]);
  assign sel_fmode = wr && (reg_addr == FMODE[8:1]);

  assign sel_dat = {NUM_PLANES{wr}} & {reg_addr == BPL8DAT[8:1],
                                       reg_addr == BPL7DAT[8:1],
                                       reg_addr == BPL6DAT[8:1],
                                       reg_addr == BPL5DAT[8:1],
                                       reg_addr == BPL4DAT[8:1],
                                       reg_addr == BPL3DAT[8:1],
                                       reg_addr == BPL2DAT[8:1],
                                       reg_addr == BPL1DAT[8:1]};

  // --------------------
  // control registers
  always_ff @(posedge clk) begin
    if (reset) begin
      dual_pf     <= 1'b0;
      pf2_pri     <= 1'b0;
      fmode       <= FMODE_16;
      bplcon1.raw <= BPLCON1_RESET;
      load        <= 1'b0;
    end else begin
      if (sel_con0)
        dual_pf <= reg_data[BPLCON0_DBLPF];
      if (sel_con2)
        pf2_pri <= reg_data[BPLCON2_PF2PRI];
      if (sel_fmode && aga)                         // ocs chips have no FMODE
        fmode <= reg_data[1:0];
      if (sel_con1)
        bplcon1.raw <= aga ? reg_data : {BPLCON1_OCS_HI, reg_data[7:0]};
      load <= sel_dat[0];                           // plane 1 write kicks all shifters
    end
  end

  // scroll values only move at the load, so a word keeps one scroll
  always_ff @(posedge clk) begin
    if (reset) begin
      pf1_scroll <= '0;
      pf2_scroll <= '0;
    end else if (load) begin
      pf1_scroll <= {bplcon1.f.pf1_hi, bplcon1.f.pf1_fine};
      pf2_scroll <= {bplcon1.f.pf2_hi, bplcon1.f.pf2_fine};
    end
  end

  // --------------------
  // plane buffers
  always_comb begin
    unique case (fmode)
      FMODE_16:       wide = '0;
      FMODE_32, 2'd2: wide = {chip48[WIDE_W-1 -: DATA_W], {(WIDE_W-DATA_W){1'b0}}};
      FMODE_64:       wide = chip48;
    endcase
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_PLANES; i++) begin
      if (sel_dat[i])
        plane_buf[i] <= {reg_data, wide};           // bus word on top
    end
  end

  assign plane1_data = plane_buf[0];
  assign plane2_data = plane_buf[1];
  assign plane3_data = plane_buf[2];
  assign plane4_data = plane_buf[3];
  assign plane5_data = plane_buf[4];
  assign plane6_data = plane_buf[5];
  assign plane7_data = plane_buf[6];
  assign plane8_data = plane_buf[7];

endmodule

/* source/bitplane_shifter.sv */
/* one bitplane serializer, msb first, one pixel per clk
   followed by a tapped history line that applies the horizontal scroll */
`timescale 1ns/1ps

module bitplane_shifter (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           load,      // copy the buffer this edge
  input  logic [1:0]                     fmode,     // fetch width of the word
  input  logic [pixel_pkg::FETCH_W-1:0]  data_in,
  input  logic [pixel_pkg::SCROLL_W-1:0] scroll,    // delay in pixels
  output logic                           out
);
  import pixel_pkg::*;

  logic [FETCH_W-1:0] keep;    // valid bits of the fetched word
  logic [FETCH_W-1:0] shreg;   // serializer, msb leaves first
  logic [FETCH_W-2:0] hist;    // hist[i] is the msb of i+1 cycles ago
  logic [FETCH_W-1:0] taps;    // current msb plus its history

  // --------------------
  // word length from the fetch mode
  always_comb begin
    unique case (fmode)
      FMODE_16:       keep = {{(FETCH_W/4){1'b1}}, {(FETCH_W*3/4){1'b0}}};
      FMODE_32, 2'd2: keep = {{(FETCH_W/2){1'b1}}, {(FETCH_W/2){1'b0}}};
      FMODE_64:       keep = '1;
    endcase
  end

  // --------------------
  // parallel to serial
  always_ff @(posedge clk) begin
    if (reset)
      shreg <= '0;
    else if (load)
      shreg <= data_in & keep;                       // unused tail shifts out as 0
    else
      shreg <= {shreg[FETCH_W-2:0], 1'b0};
  end

  // --------------------
  // scroll delay line
  always_ff @(posedge clk) begin
    if (reset)
      hist <= '0;
    else
      hist <= {hist[FETCH_W-3:0], shreg[FETCH_W-1]};
  end

  assign taps = {hist, shreg[FETCH_W-1]};              // tap 0 is undelayed
  assign out  = taps[scroll];

endmodule

/* source/playfield_priority.sv */
/* playfield priority stage, turns the eight plane bits into a colour index
   single playfield passes them on, dual playfield picks the front one */
`timescale 1ns/1ps

module playfield_priority (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [pixel_pkg::NUM_PLANES-1:0] plane_bits,   // bit 0 is plane 1
  input  logic                             dual_pf,
  input  logic                             pf2_pri,      // pf2 in front of pf1
  output logic [pixel_pkg::COLOR_W-1:0]    color
);
  import pixel_pkg::*;

  localparam int PF_W       = NUM_PLANES / 2;   // planes per playfield
  localparam int PF2_OFFSET = 8;                // pf2 uses the upper colour bank

  logic [PF_W-1:0]    pf1;         // odd planes
  logic [PF_W-1:0]    pf2;         // even planes
  logic               pf1_set;
  logic               pf2_set;
  logic [COLOR_W-1:0] pf1_color;
  logic [COLOR_W-1:0] pf2_color;
  logic [COLOR_W-1:0] color_d;

  // split planes into the two playfields
  always_comb begin
    for (int i = 0; i < PF_W; i++) begin
      pf1[i] = plane_bits[2*i];       // planes 1,3,5,7
      pf2[i] = plane_bits[2*i+1];     // planes 2,4,6,8
    end
  end

  assign pf1_set   = |pf1;            // nonzero means not transparent
  assign pf2_set   = |pf2;
  assign pf1_color = COLOR_W'(pf1);
  assign pf2_color = COLOR_W'(pf2) + COLOR_W'(PF2_OFFSET);

  // --------------------
  // priority select
  always_comb begin
    if (!dual_pf)
      color_d = plane_bits;
    else if (pf2_pri)
      color_d = pf2_set ? pf2_color : (pf1_set ? pf1_color : '0);
    else
      color_d = pf1_set ? pf1_color : (pf2_set ? pf2_color : '0);
  end

  always_ff @(posedge clk) begin
    if (reset)
      color <= '0;
    else
      color <= color_d;                // one cycle into the pixel pipe
  end

endmodule

/* source/denise_video.sv */
/* bitplane video top level, register block feeding eight plane shifters
   and the playfield priority stage that forms the colour index */
`timescale 1ns/1ps

module denise_video (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              aga,
  input  logic [8:1]                        reg_addr,   // register bus address
  input  logic [video_regs_pkg::DATA_W-1:0] reg_data,
  input  logic [video_regs_pkg::WIDE_W-1:0] chip48,
  output logic [pixel_pkg::COLOR_W-1:0]     color       // colour index, one per clk
);
  import pixel_pkg::*;

  logic                  load;
  logic [1:0]            fmode;
  logic [FETCH_W-1:0]    plane1_data;
  logic [FETCH_W-1:0]    plane2_data;
  logic [FETCH_W-1:0]    plane3_data;
  logic [FETCH_W-1:0]    plane4_data;
  logic [FETCH_W-1:0]    plane5_data;
  logic [FETCH_W-1:0]    plane6_data;
  logic [FETCH_W-1:0]    plane7_data;
  logic [FETCH_W-1:0]    plane8_data;
  logic [SCROLL_W-1:0]   pf1_scroll;
  logic [SCROLL_W-1:0]   pf2_scroll;
  logic                  dual_pf;
  logic                  pf2_pri;
  logic [NUM_PLANES-1:0] plane_bits;   // serial pixel of each plane

  // --------------------
  // registers and buffers
  bitplane_regs u_regs (
    .clk(clk), .reset(reset), .aga(aga), .reg_addr(reg_addr), .reg_data(reg_data),
    .chip48(chip48), .load(load), .fmode(fmode),
    .plane1_data(plane1_data), .plane2_data(plane2_data), .plane3_data(plane3_data),
    .plane4_data(plane4_data), .plane5_data(plane5_data), .plane6_data(plane6_data),
    .plane7_data(plane7_data), .plane8_data(plane8_data),
    .pf1_scroll(pf1_scroll), .pf2_scroll(pf2_scroll), .dual_pf(dual_pf), .pf2_pri(pf2_pri)
  );

  // --------------------
  // shifters, odd planes scroll with pf1 and even planes with pf2
  bitplane_shifter u_shift1 (.clk(clk), .reset(reset), .load(load), .fmode(fmode),
    .data_in(plane1_data), .scroll(pf1_scroll), .out(plane_bits[0]));
  bitplane_shifter u_shift2 (.clk(clk), .reset(reset), .load(load), .fmode(fmode),
    .data_in(plane2_data), .scroll(pf2_scroll), .out(plane_bits[1]));
  bitplane_shifter u_shift3 (.clk(clk), .reset(reset), .load(load), .fmode(fmode),
    .data_in(plane3_data), .scroll(pf1_scroll), .out(plane_bits[2]));
  bitplane_shifter u_shift4 (.clk(clk), .reset(reset), .load(load), .fmode(fmode),
    .data_in(plane4_data), .scroll(pf2_scroll), .out(plane_bits[3]));
  bitplane_shifter u_shift5 (.clk(clk), .reset(reset), .load(load), .fmode(fmode),
    .data_in(plane5_data), .scroll(pf1_scroll), .out(plane_bits[4]));
  bitplane_shifter u_shift6 (.clk(clk), .reset(reset), .load(load), .fmode(fmode),
    .data_in(plane6_data), .scroll(pf2_scroll), .out(plane_bits[5]));
  bitplane_shifter u_shift7 (.clk(clk), .reset(reset), .load(load), .fmode(fmode),
    .data_in(plane7_data), .scroll(pf1_scroll), .out(plane_bits[6]));
  bitplane_shifter u_shift8 (.clk(clk), .reset(reset), .load(load), .fmode(fmode),
    .data_in(plane8_data), .scroll(pf2_scroll), .out(plane_bits[7]));

  // --------------------
  // colour index
  playfield_priority u_prio (
    .clk(clk), .reset(reset), .plane_bits(plane_bits),
    .dual_pf(dual_pf), .pf2_pri(pf2_pri), .color(color)
  );

endmodule

/* sim/tb_clock.sv */
/* testbench clock and reset source, 20 ns clk
   reset held high for the first 10 rising edges */
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
  end

  always #10 clk = ~clk;   // 50 MHz pixel clock

  initial begin
    repeat (10) @(posedge clk);
    #2 reset = 1'b0;       // released off the edge, like the other inputs
  end

endmodule

/* sim/denise_video_sva.sv */
/* protocol checks on the bitplane register block
   bound into every bitplane_regs instance from this file */
`timescale 1ns/1ps

module denise_video_sva (
  input logic                             clk,
  input logic                             reset,
  input logic                             aga,
  input logic [8:1]                       reg_addr,
  input logic                             load,
  input logic [1:0]                       fmode,
  input logic [pixel_pkg::SCROLL_W-1:0]   pf1_scroll,
  input logic [pixel_pkg::SCROLL_W-1:0]   pf2_scroll
);
  import video_regs_pkg::*;

  // --------------------
  // load pulse
  a_load_single: assert property (@(posedge clk) disable iff (reset) load |=> !load)
    else $error("load high for two cycles");
  a_load_follows: assert property (@(posedge clk) disable iff (reset)
    (reg_addr == BPL1DAT[8:1]) |=> load) else $error("no load after BPL1DAT write");
  a_load_cause: assert property (@(posedge clk) disable iff (reset)
    load |-> ($past(reg_addr) == BPL1DAT[8:1])) else $error("load without BPL1DAT write");

  // ocs writes leave the fetch mode alone
  a_fmode_ocs: assert property (@(posedge clk) disable iff (reset)
    (!aga && reg_addr != REG_IDLE[8:1]) |=> $stable(fmode)) else $error("fmode moved");

  // scroll only moves right after a load
  a_scroll: assert property (@(posedge clk) disable iff (reset)
    (!$stable(pf1_scroll) || !$stable(pf2_scroll)) |-> $past(load))
    else $error("scroll changed outside load");

endmodule

bind bitplane_regs denise_video_sva u_sva (
  .clk(clk), .reset(reset), .aga(aga), .reg_addr(reg_addr), .load(load),
  .fmode(fmode), .pf1_scroll(pf1_scroll), .pf2_scroll(pf2_scroll)
);

/* sim/denise_video_tb.sv */
/* testbench for the bitplane video path that drives random register and plane writes
   against a cycle model of the pixel stream and the playfield priority */
`timescale 1ns/1ps

module denise_video_tb;
  import video_regs_pkg::*;
  import pixel_pkg::*;

  logic        clk;
  logic        reset;
  logic        aga;
  logic [8:1]  reg_addr;
  logic [15:0] reg_data;
  logic [47:0] chip48;
  logic [7:0]  color;

  logic [31:0] lfsr = 32'h5718_4234;
  int          cyc;                        // rising edges seen so far
  realtime     edge_time;
  int          errors;
  int          test_errors;
  int          tests_run;

  // model state
  logic        m_load;
  logic [1:0]  m_fmode;
  logic [15:0] m_con1;
  logic        m_dual;
  logic        m_pri;
  logic [63:0] m_buf [NUM_PLANES];
  logic [63:0] m_sh [NUM_PLANES];
  logic [5:0]  m_scroll [NUM_PLANES];
  logic        msb_line [NUM_PLANES][1024];   // undelayed pixel of each plane by cycle
  logic [7:0]  m_bits;
  logic [7:0]  exp_color;

  tb_clock u_clock (.clk(clk), .reset(reset));

  denise_video u_denise_video (
    .clk(clk), .reset(reset), .aga(aga), .reg_addr(reg_addr),
    .reg_data(reg_data), .chip48(chip48), .color(color)
  );

  // --------------------
  // helpers
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = galois_step(lfsr);
      v = {v[62:0], lfsr[0]};                // one step per bit
    end
    return v;
  endfunction

  function automatic logic [8:1] dat_addr(input int p);
    logic [8:0] a;
    a = BPL1DAT + 9'(2 * p);
    return a[8:1];
  endfunction

  function automatic logic [63:0] keep_mask(input logic [1:0] fm);
    if (fm == 2'd0) return {16'hffff, 48'h0};
    if (fm == 2'd3) return '1;
    return {32'hffff_ffff, 32'h0};             // codes 1 and 2
  endfunction

  function automatic logic [47:0] wide_bits(input logic [1:0] fm, input logic [47:0] c);
    if (fm == 2'd0) return '0;
    if (fm == 2'd3) return c;
    return {c[47:32], 32'h0};
  endfunction

  function automatic logic [7:0] prio(input logic [7:0] bits, input logic dual, input logic pri);
    logic [3:0] pf1;
    logic [3:0] pf2;
    logic [7:0] c1;
    logic [7:0] c2;
    pf1 = {bits[6], bits[4], bits[2], bits[0]};
    pf2 = {bits[7], bits[5], bits[3], bits[1]};
    c1 = {4'h0, pf1};
    c2 = {4'h0, pf2} + 8'd8;                   // pf2 colours sit in the upper bank
    if (!dual) return bits;
    if (pri) return (pf2 != 4'h0) ? c2 : ((pf1 != 4'h0) ? c1 : 8'h00);
    return (pf1 != 4'h0) ? c1 : ((pf2 != 4'h0) ? c2 : 8'h00);
  endfunction

  // --------------------
  // cycle model updated on every rising edge from the driven inputs
  always @(posedge clk) begin : model
    cyc++;
    edge_time = $realtime;
    if (reset) begin
      m_load = 1'b0;
      m_fmode = 2'd0;
      m_con1 = 16'h3300;
      m_dual = 1'b0;
      m_pri = 1'b0;
      m_bits = '0;
      exp_color = '0;
      for (int p = 0; p < NUM_PLANES; p++) begin
        m_sh[p] = '0;
        m_scroll[p] = '0;
        for (int i = 0; i < 1024; i++)
          msb_line[p][i] = 1'b0;
      end
    end else begin
      exp_color = prio(m_bits, m_dual, m_pri);   // registered stage
      for (int p = 0; p < NUM_PLANES; p++) begin
        if (m_load) begin
          m_sh[p] = m_buf[p] & keep_mask(m_fmode);
          m_scroll[p] = (p % 2 == 0) ? {m_con1[11:10], m_con1[3:0]}
                                     : {m_con1[15:14], m_con1[7:4]};
        end else
          m_sh[p] = m_sh[p] << 1;
        msb_line[p][cyc & 1023] = m_sh[p][63];
        m_bits[p] = msb_line[p][(cyc - int'(m_scroll[p])) & 1023];
      end
      // bus write taking effect at this edge
      if (reg_addr == BPLCON0[8:1]) m_dual = reg_data[10];
      if (reg_addr == BPLCON2[8:1]) m_pri = reg_data[6];
      if (reg_addr == BPLCON1[8:1]) m_con1 = aga ? reg_data : {8'h33, reg_data[7:0]};
      for (int p = 0; p < NUM_PLANES; p++)
        if (reg_addr == dat_addr(p)) m_buf[p] = {reg_data, wide_bits(m_fmode, chip48)};
      if (reg_addr == FMODE[8:1] && aga) m_fmode = reg_data[1:0];
      m_load = (reg_addr == BPL1DAT[8:1]);
    end
  end

  // --------------------
  // stimulus tasks
  task automatic abort_run(input string why);
    $display("Timeout waiting for %s at %0t", why, $time);
    $display("Test failures found");
    $finish;
  endtask

  // wait for the next edge and check color 1 ns after it, then return 2 ns after it
  task automatic tick();
    int start;
    int polls;
    start = cyc;
    polls = 0;
    while (cyc == start && polls < 40) begin
      #1;
      polls++;
    end
    if (cyc == start) begin
      abort_run("clock edge");
    end else begin
      #(edge_time + 1.0 - $realtime);
      if (color !== exp_color) begin
        $display("Error: time %0t color expected %h actual %h", $time, exp_color, color);
        test_errors++;
      end
      #1;
    end
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++)
      tick();
  endtask

  task automatic write_reg(input logic [8:1] addr, input logic [15:0] data);
    reg_addr = addr;
    reg_data = data;
    chip48 = 48'(rand_bits(48));
    tick();
    reg_addr = REG_IDLE[8:1];
  endtask

  // plane 1 goes last since its write fires the load
  task automatic load_planes();
    for (int p = NUM_PLANES - 1; p >= 0; p--)
      write_reg(dat_addr(p), 16'(rand_bits(16)));
  endtask

  task automatic finish_test(input string name);
    $display("%s: %0d errors", name, test_errors);
    errors += test_errors;
    test_errors = 0;
    tests_run++;
  endtask

  // --------------------
  // test sequence
  task automatic run_tests();
    idle(20);                                  // color must hold at 0
    for (int p = NUM_PLANES - 1; p > 0; p--)
      write_reg(dat_addr(p), 16'h0000);
    write_reg(BPL1DAT[8:1], 16'(rand_bits(16)));
    idle(70);
    finish_test("reset and single plane");

    repeat (3) begin
      load_planes();
      idle(70);
    end
    finish_test("16 bit words");

    aga = 1'b1;
    repeat (4) begin
      write_reg(FMODE[8:1], 16'(rand_bits(2)));
      load_planes();
      idle(70);
    end
    // planes 8 to 2 hold 64 bit words but the load sees a 16 bit fetch
    write_reg(FMODE[8:1], 16'(FMODE_64));
    for (int p = NUM_PLANES - 1; p > 0; p--)
      write_reg(dat_addr(p), 16'(rand_bits(16)));
    write_reg(FMODE[8:1], 16'(FMODE_16));
    write_reg(BPL1DAT[8:1], 16'(rand_bits(16)));
    idle(70);
    aga = 1'b0;
    write_reg(FMODE[8:1], {14'(rand_bits(14)), FMODE_64});  // ignored without aga
    load_planes();
    idle(70);
    finish_test("wide fetch");

    repeat (4) begin
      aga = rand_bits(1) != 64'd0;
      write_reg(BPLCON1[8:1], 16'(rand_bits(16)));
      load_planes();
      idle(140);
    end
    finish_test("scroll");

    write_reg(BPLCON0[8:1], 16'h0400);
    repeat (4) begin
      write_reg(BPLCON2[8:1], 16'(rand_bits(16)));
      load_planes();
      idle(140);
    end
    finish_test("dual playfield");

    repeat (4) begin
      load_planes();
      idle(1 + int'(rand_bits(3)));
      write_reg(BPL1DAT[8:1], 16'(rand_bits(16)));   // abandons the word in flight
      idle(140);
    end
    finish_test("back to back loads");

    $display("Tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  endtask

  initial begin
    aga = 1'b0;
    reg_addr = REG_IDLE[8:1];
    reg_data = '0;
    chip48 = '0;
    cyc = 0;
    edge_time = 0;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    for (int i = 0; i < 40 && reset; i++)
      tick();
    if (reset)
      abort_run("reset release");
    else
      run_tests();
  end

endmodule

/* sources.f */
source/video_regs_pkg.sv
source/pixel_pkg.sv
source/bitplane_regs.sv
source/bitplane_shifter.sv
source/playfield_priority.sv
source/denise_video.sv
sim/tb_clock.sv
sim/denise_video_sva.sv
sim/denise_video_tb.sv

/* Makefile */
# Verilator build for the bitplane video testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = denise_video_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation output is searched for the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
